//--- design/ialu_arch_pkg.sv
//----------------------------------------------------------
// Datapath definitions of the integer ALU: word widths,
// adder flag positions and iterative multiplier sizing.
//----------------------------------------------------------

package ialu_arch_pkg;

    localparam int xlen  = 32;                  // Data width
    localparam int cnt_w = 5;                   // Iteration counter width

    // Adder flag bit positions
    localparam int flag_c = 0;                  // Carry (borrow on subtract)
    localparam int flag_z = 1;                  // Zero
    localparam int flag_s = 2;                  // Sign
    localparam int flag_o = 3;                  // Signed overflow

    typedef logic [xlen-1:0]  word_t;           // Operand or result word
    typedef logic [xlen:0]    word_ext_t;       // Word plus carry/sign bit
    typedef logic [4:0]       shamt_t;          // Shift amount
    typedef logic [3:0]       flags_t;          // Adder flags
    typedef logic [cnt_w-1:0] cnt_t;            // Multiplier step count

    // Initial step count, one less than the number of steps
    function automatic int mul_init_cnt(input int step_bits);
        return xlen / step_bits - 1;
    endfunction

endpackage

//--- design/ialu_ctrl_pkg.sv
//----------------------------------------------------------
// Control definitions of the integer ALU: the command set,
// the multiply kind and the control FSM states.
//----------------------------------------------------------

package ialu_ctrl_pkg;

    typedef enum logic [4:0] {
        CMD_NONE   = 5'd0,
        CMD_ADD    = 5'd1,
        CMD_SUB    = 5'd2,
        CMD_AND    = 5'd3,
        CMD_OR     = 5'd4,
        CMD_XOR    = 5'd5,
        CMD_SLT    = 5'd6,                      // Compares, all done by subtraction
        CMD_SLTU   = 5'd7,
        CMD_EQ     = 5'd8,
        CMD_NE     = 5'd9,
        CMD_GE     = 5'd10,
        CMD_GEU    = 5'd11,
        CMD_SLL    = 5'd12,                     // Shifts by op2[4:0]
        CMD_SRL    = 5'd13,
        CMD_SRA    = 5'd14,
        CMD_MUL    = 5'd15,                     // Iterative multiplies
        CMD_MULH   = 5'd16,
        CMD_MULHSU = 5'd17,
        CMD_MULHU  = 5'd18
    } ialu_cmd_e;

    // Bit 1 set means op2 unsigned, bit 0 set means high half (or both unsigned)
    // 00 MUL, 01 MULH, 10 MULHSU, 11 MULHU
    typedef logic [1:0] mul_kind_t;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_ITER = 1'b1
    } fsm_state_e;

endpackage

//--- design/ialu_main_adder.sv
//----------------------------------------------------------
// Main add/subtract unit of the ALU. Produces the sum and the
// compare flags, and serves as the multiplier step counter
// while a multiply is in progress.
//----------------------------------------------------------
`timescale 1ns/1ns

module ialu_main_adder #(
    parameter int mul_step_bits = 1
) (
    input  ialu_arch_pkg::word_t      ialu_op1,
    input  ialu_arch_pkg::word_t      ialu_op2,
    input  logic                      add_sub,
    input  logic                      mul_vd,
    input  ialu_ctrl_pkg::fsm_state_e state,
    input  ialu_arch_pkg::cnt_t       cnt_reg,
    output ialu_arch_pkg::word_ext_t  sum_res,
    output ialu_arch_pkg::flags_t     flags
);

    import ialu_arch_pkg::*;
    import ialu_ctrl_pkg::*;

    localparam word_t init_cnt = word_t'(mul_init_cnt(mul_step_bits));

    logic  sum_sub;                             // 1 - subtract
    word_t sum_op1;
    word_t sum_op2;

    //------------------------------------------------------------
    // Operand select and adder
    //------------------------------------------------------------
    always_comb begin
        sum_sub = add_sub;
        sum_op1 = ialu_op1;
        sum_op2 = ialu_op2;
        if (mul_vd) begin
            // Count down, borrow marks the last step
            sum_sub = 1'b1;
            sum_op1 = (state == ST_IDLE) ? init_cnt : word_t'(cnt_reg);
            sum_op2 = word_t'(1);
        end
        sum_res = sum_sub ? ({1'b0, sum_op1} - {1'b0, sum_op2})
                          : ({1'b0, sum_op1} + {1'b0, sum_op2});
    end

    //------------------------------------------------------------
    // Flags
    //------------------------------------------------------------
    always_comb begin
        flags[flag_c] = sum_res[xlen];                  // Borrow gives unsigned less-than
        flags[flag_z] = ~|sum_res[xlen-1:0];
        flags[flag_s] = sum_res[xlen-1];
        flags[flag_o] = (~sum_op1[xlen-1] &  sum_op2[xlen-1] &  sum_res[xlen-1])
                      | ( sum_op1[xlen-1] & ~sum_op2[xlen-1] & ~sum_res[xlen-1]);
    end

endmodule

//--- design/ialu_mul_iter.sv
//----------------------------------------------------------
// Iterative shift-add multiplier. Retires mul_step_bits of
// op2 per cycle with its own step adder and keeps the
// partial product and the step count in registers.
//----------------------------------------------------------
`timescale 1ns/1ns

module ialu_mul_iter #(
    parameter int mul_step_bits = 1
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  ialu_arch_pkg::word_t      ialu_op1,
    input  ialu_arch_pkg::word_t      ialu_op2,
    input  logic                      mul_vd,
    input  ialu_ctrl_pkg::mul_kind_t  mul_kind,
    input  ialu_ctrl_pkg::fsm_state_e state,
    input  logic                      busy,
    input  ialu_arch_pkg::word_ext_t  sum_res,
    input  ialu_arch_pkg::flags_t     flags,
    output ialu_arch_pkg::cnt_t       cnt_reg,
    output ialu_arch_pkg::word_t      mul_hi,
    output ialu_arch_pkg::word_t      mul_lo
);

    import ialu_arch_pkg::*;
    import ialu_ctrl_pkg::*;

    localparam int prod_w = xlen + mul_step_bits;

    logic                          op1_sgn;     // Op1 taken as signed
    logic                          op2_sgn;     // Op2 taken as signed
    logic                          last_step;
    word_t                         op2_src;     // Remaining op2 bits
    logic signed [xlen:0]          mul_op1;
    logic signed [mul_step_bits:0] mul_op2;
    logic signed [prod_w-1:0]      mul_prod;
    logic signed [xlen:0]          part_hi;
    logic signed [prod_w-1:0]      step_sum;
    word_t                         hi_reg;      // High partial product
    word_t                         lo_reg;      // Low product bits and unused op2

    assign op1_sgn   = ~&mul_kind;
    assign op2_sgn   = ~mul_kind[1];
    assign last_step = flags[flag_c];           // Counter borrow from the main adder
    assign op2_src   = (state == ST_IDLE) ? ialu_op2 : lo_reg;

    //------------------------------------------------------------
    // Step product and step adder
    //------------------------------------------------------------
    always_comb begin
        mul_op1 = signed'({op1_sgn & ialu_op1[xlen-1], ialu_op1});
        // Top slice of a signed op2 has negative weight
        mul_op2 = signed'({op2_sgn & ialu_op2[xlen-1] & last_step,
                           op2_src[mul_step_bits-1:0]});
        mul_prod = mul_op1 * mul_op2;
        part_hi  = (state == ST_IDLE) ? '0
                                      : signed'({op1_sgn & hi_reg[xlen-1], hi_reg});
        step_sum = part_hi + mul_prod;
    end

    assign mul_hi = step_sum[prod_w-1:mul_step_bits];
    assign mul_lo = {step_sum[mul_step_bits-1:0], op2_src[xlen-1:mul_step_bits]};

    //------------------------------------------------------------
    // Iteration registers
    //------------------------------------------------------------
    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            cnt_reg <= '0;
            hi_reg  <= '0;
            lo_reg  <= '0;
        end else if (busy & mul_vd) begin
            cnt_reg <= sum_res[cnt_w-1:0];      // Next count
            hi_reg  <= mul_hi;
            lo_reg  <= mul_lo;                  // Shifted right with spilled bits
        end
    end

endmodule

//--- design/ialu_ctrl_fsm.sv
//----------------------------------------------------------
// Control FSM of the ALU. Steps through IDLE and ITER for a
// multiply and forms the ready and busy levels.
//----------------------------------------------------------
`timescale 1ns/1ns

module ialu_ctrl_fsm (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      ialu_vd,
    input  logic                      mul_vd,
    input  ialu_arch_pkg::word_t      ialu_op1,
    input  ialu_arch_pkg::word_t      ialu_op2,
    input  ialu_arch_pkg::flags_t     flags,
    output ialu_ctrl_pkg::fsm_state_e state,
    output logic                      ialu_rdy,
    output logic                      ialu_busy
);

    import ialu_arch_pkg::*;
    import ialu_ctrl_pkg::*;

    fsm_state_e next_state;
    logic       iter_req;                       // Multiply needs iteration
    logic       iter_rdy;                       // Last step reached

    // A zero operand gives a zero product without iterating
    assign iter_req = ialu_vd & mul_vd & (|ialu_op1) & (|ialu_op2) & (state == ST_IDLE);
    assign iter_rdy = mul_vd & flags[flag_c] & (state == ST_ITER);

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (iter_req) begin
                    next_state = ST_ITER;
                end
            end
            ST_ITER: begin
                if (iter_rdy) begin
                    next_state = ST_IDLE;
                end
            end
            default: next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            state <= ST_IDLE;
        end else if (~ialu_vd) begin
            state <= ST_IDLE;                   // Dropped request aborts
        end else begin
            state <= next_state;
        end
    end

    assign ialu_rdy  = ~(iter_req | ((state == ST_ITER) & mul_vd & ~iter_rdy));
    assign ialu_busy = ialu_vd & ~ialu_rdy;

endmodule

//--- design/ialu_result_mux.sv
//----------------------------------------------------------
// Command decode and result forming of the ALU: bitwise
// logic, shifter, compare flag and the final result select.
//----------------------------------------------------------
`timescale 1ns/1ns

module ialu_result_mux (
    input  ialu_arch_pkg::word_t      ialu_op1,
    input  ialu_arch_pkg::word_t      ialu_op2,
    input  ialu_ctrl_pkg::ialu_cmd_e  ialu_cmd,
    input  ialu_ctrl_pkg::fsm_state_e state,
    input  ialu_arch_pkg::word_ext_t  sum_res,
    input  ialu_arch_pkg::flags_t     flags,
    input  ialu_arch_pkg::word_t      mul_hi,
    input  ialu_arch_pkg::word_t      mul_lo,
    output logic                      add_sub,
    output logic                      mul_vd,
    output ialu_ctrl_pkg::mul_kind_t  mul_kind,
    output ialu_arch_pkg::word_t      ialu_res,
    output logic                      ialu_cmp
);

    import ialu_arch_pkg::*;
    import ialu_ctrl_pkg::*;

    shamt_t shamt;
    logic   cmp_vd;                             // Command is a compare
    logic   cmp_flag;
    logic   cmp_inv;

    //------------------------------------------------------------
    // Decode
    //------------------------------------------------------------
    assign add_sub  = (ialu_cmd != CMD_ADD);    // Compares subtract too
    assign mul_vd   = (ialu_cmd == CMD_MUL) | (ialu_cmd == CMD_MULH)
                    | (ialu_cmd == CMD_MULHSU) | (ialu_cmd == CMD_MULHU);
    assign mul_kind = {(ialu_cmd == CMD_MULHU) | (ialu_cmd == CMD_MULHSU),
                       (ialu_cmd == CMD_MULHU) | (ialu_cmd == CMD_MULH)};
    assign shamt    = ialu_op2[4:0];

    // Compare flag from the subtraction
    always_comb begin
        cmp_vd   = 1'b1;
        cmp_flag = 1'b0;
        case (ialu_cmd)
            CMD_SLT, CMD_GE:   cmp_flag = flags[flag_s] ^ flags[flag_o];
            CMD_SLTU, CMD_GEU: cmp_flag = flags[flag_c];
            CMD_EQ, CMD_NE:    cmp_flag = flags[flag_z];
            default:           cmp_vd   = 1'b0;
        endcase
        cmp_inv = (ialu_cmd == CMD_GE) | (ialu_cmd == CMD_GEU) | (ialu_cmd == CMD_NE);
    end

    assign ialu_cmp = cmp_vd & (cmp_flag ^ cmp_inv);

    //------------------------------------------------------------
    // Result select
    //------------------------------------------------------------
    always_comb begin
        ialu_res = '0;
        case (ialu_cmd)
            CMD_ADD, CMD_SUB: ialu_res = sum_res[xlen-1:0];
            CMD_AND:          ialu_res = ialu_op1 & ialu_op2;
            CMD_OR:           ialu_res = ialu_op1 | ialu_op2;
            CMD_XOR:          ialu_res = ialu_op1 ^ ialu_op2;
            CMD_SLT, CMD_SLTU, CMD_EQ,
            CMD_NE, CMD_GE, CMD_GEU: begin
                ialu_res = word_t'(ialu_cmp);   // 0/1 word
            end
            CMD_SLL:          ialu_res = ialu_op1 << shamt;
            CMD_SRL:          ialu_res = ialu_op1 >> shamt;
            CMD_SRA:          ialu_res = word_t'(signed'(ialu_op1) >>> shamt);
            CMD_MUL, CMD_MULH, CMD_MULHSU, CMD_MULHU: begin
                // Zero in IDLE covers the zero-operand shortcut
                if (state == ST_ITER) begin
                    ialu_res = (|mul_kind) ? mul_hi : mul_lo;
                end
            end
            default:          ialu_res = '0;
        endcase
    end

endmodule

//--- design/ialu_top.sv
//----------------------------------------------------------
// Top level of the integer ALU. Connects the main adder,
// the iterative multiplier, the control FSM and the result
// mux, and sets the multiplier step width.
//----------------------------------------------------------
`timescale 1ns/1ns

module ialu_top #(
    parameter int mul_step_bits = 1             // Op2 bits per multiply step
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     ialu_vd,
    input  ialu_arch_pkg::word_t     ialu_op1,
    input  ialu_arch_pkg::word_t     ialu_op2,
    input  ialu_ctrl_pkg::ialu_cmd_e ialu_cmd,
    output ialu_arch_pkg::word_t     ialu_res,
    output logic                     ialu_cmp,
    output logic                     ialu_rdy,
    output logic                     ialu_busy
);

    import ialu_arch_pkg::*;
    import ialu_ctrl_pkg::*;

    logic       add_sub;
    logic       mul_vd;
    mul_kind_t  mul_kind;
    fsm_state_e state;
    word_ext_t  sum_res;
    flags_t     flags;
    cnt_t       cnt_reg;
    word_t      mul_hi;
    word_t      mul_lo;

    ialu_main_adder #(
        .mul_step_bits (mul_step_bits)
    ) u_main_adder (
        .ialu_op1 (ialu_op1),
        .ialu_op2 (ialu_op2),
        .add_sub  (add_sub),
        .mul_vd   (mul_vd),
        .state    (state),
        .cnt_reg  (cnt_reg),
        .sum_res  (sum_res),
        .flags    (flags)
    );

    ialu_mul_iter #(
        .mul_step_bits (mul_step_bits)
    ) u_mul_iter (
        .clk      (clk),
        .rst_n    (rst_n),
        .ialu_op1 (ialu_op1),
        .ialu_op2 (ialu_op2),
        .mul_vd   (mul_vd),
        .mul_kind (mul_kind),
        .state    (state),
        .busy     (ialu_busy),
        .sum_res  (sum_res),
        .flags    (flags),
        .cnt_reg  (cnt_reg),
        .mul_hi   (mul_hi),
        .mul_lo   (mul_lo)
    );

    ialu_ctrl_fsm u_ctrl_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .ialu_vd   (ialu_vd),
        .mul_vd    (mul_vd),
        .ialu_op1  (ialu_op1),
        .ialu_op2  (ialu_op2),
        .flags     (flags),
        .state     (state),
        .ialu_rdy  (ialu_rdy),
        .ialu_busy (ialu_busy)
    );

    ialu_result_mux u_result_mux (
        .ialu_op1 (ialu_op1),
        .ialu_op2 (ialu_op2),
        .ialu_cmd (ialu_cmd),
        .state    (state),
        .sum_res  (sum_res),
        .flags    (flags),
        .mul_hi   (mul_hi),
        .mul_lo   (mul_lo),
        .add_sub  (add_sub),
        .mul_vd   (mul_vd),
        .mul_kind (mul_kind),
        .ialu_res (ialu_res),
        .ialu_cmp (ialu_cmp)
    );

endmodule

//--- dv/ialu_checker.sv
//----------------------------------------------------------
// Assertions on the ALU control FSM. Bound into every
// ialu_ctrl_fsm instance at the end of this file.
//----------------------------------------------------------
`timescale 1ns/1ns

module ialu_checker (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      ialu_vd,
    input logic                      mul_vd,
    input ialu_arch_pkg::word_t      ialu_op1,
    input ialu_arch_pkg::word_t      ialu_op2,
    input ialu_ctrl_pkg::fsm_state_e state,
    input logic                      ialu_busy
);

    import ialu_ctrl_pkg::*;

    logic mul_req;                              // Multiply that has to iterate

    assign mul_req = ialu_vd & mul_vd & (|ialu_op1) & (|ialu_op2) & (state == ST_IDLE);

    a_idle_to_iter: assert property (@(posedge clk) disable iff (!rst_n)
        mul_req |=> (state == ST_ITER))
        else $error("IDLE did not move to ITER on a multiply request");

    a_idle_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ((state == ST_IDLE) && !mul_req) |=> (state == ST_IDLE))
        else $error("IDLE left without a multiply request");

    a_drop_to_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !ialu_vd |=> (state == ST_IDLE))
        else $error("State not IDLE one cycle after valid dropped");

    a_no_busy_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !ialu_vd |-> !ialu_busy)
        else $error("Busy shown while valid is low");

    a_vd_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(ialu_vd))
        else $error("Valid is unknown after reset");

endmodule

bind ialu_ctrl_fsm ialu_checker u_ialu_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .ialu_vd   (ialu_vd),
    .mul_vd    (mul_vd),
    .ialu_op1  (ialu_op1),
    .ialu_op2  (ialu_op2),
    .state     (state),
    .ialu_busy (ialu_busy)
);

//--- dv/ialu_tb.sv
//----------------------------------------------------------
// Testbench of the integer ALU. Runs every command on random
// and edge operands, checks results against a reference
// model and checks the ready and busy timing.
//----------------------------------------------------------
`timescale 1ns/1ns

module ialu_tb;

    import ialu_arch_pkg::*;
    import ialu_ctrl_pkg::*;

    localparam int mul_step_bits = 1;
    localparam int n_rounds      = 12;          // Passes over the whole command set
    localparam int n_ops         = n_rounds * 18 + 10;
    localparam int timeout_cyc   = n_ops * 40 + 100;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      ialu_vd;
    word_t     ialu_op1;
    word_t     ialu_op2;
    ialu_cmd_e ialu_cmd;
    word_t     ialu_res;
    logic      ialu_cmp;
    logic      ialu_rdy;
    logic      ialu_busy;

    integer    seed = 32'h1201;
    int        n_issued = 0;
    int        n_checked = 0;

    always #5 clk = ~clk;

    ialu_top #(
        .mul_step_bits (mul_step_bits)
    ) u_ialu_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .ialu_vd   (ialu_vd),
        .ialu_op1  (ialu_op1),
        .ialu_op2  (ialu_op2),
        .ialu_cmd  (ialu_cmd),
        .ialu_res  (ialu_res),
        .ialu_cmp  (ialu_cmp),
        .ialu_rdy  (ialu_rdy),
        .ialu_busy (ialu_busy)
    );

    //------------------------------------------------------------
    // Reference model and compare tasks
    //------------------------------------------------------------
    function automatic word_t ref_alu(input ialu_cmd_e cmd, input word_t a, input word_t b,
                                      output logic cmp);
        logic [63:0] pa;
        logic [63:0] pb;
        logic [63:0] prod;
        word_t       res;
        pa   = (cmd == CMD_MULHU) ? {32'b0, a} : {{32{a[31]}}, a};
        pb   = (cmd == CMD_MULHU || cmd == CMD_MULHSU) ? {32'b0, b} : {{32{b[31]}}, b};
        prod = pa * pb;                         // Low 64 bits are exact for all kinds
        cmp  = 1'b0;
        res  = '0;
        case (cmd)
            CMD_ADD:  res = a + b;
            CMD_SUB:  res = a - b;
            CMD_AND:  res = a & b;
            CMD_OR:   res = a | b;
            CMD_XOR:  res = a ^ b;
            CMD_SLT:  cmp = $signed(a) < $signed(b);
            CMD_SLTU: cmp = a < b;
            CMD_EQ:   cmp = a == b;
            CMD_NE:   cmp = a != b;
            CMD_GE:   cmp = $signed(a) >= $signed(b);
            CMD_GEU:  cmp = a >= b;
            CMD_SLL:  res = a << b[4:0];
            CMD_SRL:  res = a >> b[4:0];
            CMD_SRA:  res = word_t'($signed(a) >>> b[4:0]);
            CMD_MUL:  res = prod[31:0];
            CMD_MULH, CMD_MULHSU, CMD_MULHU: res = prod[63:32];
            default:  res = '0;
        endcase
        if (cmp) begin
            res = 32'd1;                        // Compares give a 0/1 word
        end
        return res;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            report_failure($sformatf("ERROR %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_cmp(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("ERROR %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("ERROR %s: got %h, expected %h", name, got, exp));
        end
    endtask

    // Every accepted result is checked here
    always @(posedge clk) begin
        word_t exp_res;
        logic  exp_cmp;
        if (rst_n && ialu_vd && ialu_rdy) begin
            exp_res = ref_alu(ialu_cmd, ialu_op1, ialu_op2, exp_cmp);
            check_word("ialu_res", ialu_res, exp_res);
            check_cmp("ialu_cmp", ialu_cmp, exp_cmp);
            n_checked++;
        end
    end

    //------------------------------------------------------------
    // Stimulus tasks
    //------------------------------------------------------------
    task automatic pick_operands(output word_t a, output word_t b);
        int sel;
        a   = $random(seed);
        b   = $random(seed);
        sel = $unsigned($random(seed)) % 10;
        case (sel)
            0: a = '0;
            1: b = '0;
            2: b = a;                           // Equal values
            3: a = 32'h8000_0000;
            4: b = 32'h8000_0000;
            default: ;
        endcase
    endtask

    task automatic run_op(input ialu_cmd_e cmd, input word_t a, input word_t b);
        logic is_mul;
        int   exp_lat;
        int   lat;
        is_mul  = cmd inside {CMD_MUL, CMD_MULH, CMD_MULHSU, CMD_MULHU};
        exp_lat = (is_mul && a != 0 && b != 0) ? xlen / mul_step_bits : 1;
        @(negedge clk);
        ialu_vd  = 1'b1;
        ialu_cmd = cmd;
        ialu_op1 = a;
        ialu_op2 = b;
        n_issued++;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
            check_level("ialu_busy", ialu_busy, (lat < exp_lat));   // Busy until the ready cycle
        end while (!ialu_rdy && lat < 2 * exp_lat + 4);
        if (!ialu_rdy) begin
            report_failure($sformatf("ialu_rdy never rose for command %s", cmd.name()));
        end
        if (lat != exp_lat) begin
            report_failure($sformatf("ialu_rdy rose after %0d cycles instead of %0d for %s",
                                     lat, exp_lat, cmd.name()));
        end
    endtask

    task automatic idle_cycles(input int n);
        @(negedge clk);
        ialu_vd = 1'b0;
        repeat (n) begin
            @(posedge clk);
            check_level("ialu_busy", ialu_busy, 1'b0);
        end
    endtask

    // Multiply dropped part way through its iteration
    task automatic abort_mul(input word_t a, input word_t b, input int n);
        @(negedge clk);
        ialu_vd  = 1'b1;
        ialu_cmd = CMD_MUL;
        ialu_op1 = a;
        ialu_op2 = b;
        repeat (n) begin
            @(posedge clk);
            check_level("ialu_rdy", ialu_rdy, 1'b0);
        end
        idle_cycles(2);
    endtask

    //------------------------------------------------------------
    // Test sequence and watchdog
    //------------------------------------------------------------
    initial begin
        word_t a;
        word_t b;
        rst_n    = 1'b0;
        ialu_vd  = 1'b0;
        ialu_cmd = CMD_NONE;
        ialu_op1 = '0;
        ialu_op2 = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(posedge clk);
        check_level("ialu_rdy", ialu_rdy, 1'b1);    // Idle after reset
        check_level("ialu_busy", ialu_busy, 1'b0);
        for (int r = 0; r < n_rounds; r++) begin
            for (int c = int'(CMD_ADD); c <= int'(CMD_MULHU); c++) begin
                pick_operands(a, b);
                run_op(ialu_cmd_e'(c), a, b);
            end
            if (r % 3 == 0) begin
                idle_cycles(2);
            end
        end
        run_op(CMD_SLT, 32'h8000_0000, 32'h0);
        run_op(CMD_GEU, 32'h1234_5678, 32'h1234_5678);
        run_op(CMD_SRA, 32'h8000_0001, 32'd31);
        run_op(CMD_MUL, 32'h0, 32'hdead_beef);
        run_op(CMD_MULHU, 32'hffff_ffff, 32'h0);
        abort_mul(32'h0000_0007, 32'hffff_fff3, 5);
        run_op(CMD_MULHSU, 32'hffff_fffe, 32'hffff_ffff);
        idle_cycles(2);
        if (n_checked == n_issued) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            report_failure($sformatf("%0d results checked for %0d commands",
                                     n_checked, n_issued));
        end
    end

    initial begin
        repeat (timeout_cyc) @(posedge clk);
        report_failure("watchdog timeout, the ALU stopped answering");
    end

endmodule

//--- flist.f
design/ialu_arch_pkg.sv
design/ialu_ctrl_pkg.sv
design/ialu_main_adder.sv
design/ialu_mul_iter.sv
design/ialu_ctrl_fsm.sv
design/ialu_result_mux.sv
design/ialu_top.sv
dv/ialu_checker.sv
dv/ialu_tb.sv

//--- Makefile
# Verilator build and run of the integer ALU testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := ialu_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG) || ! grep -q "SIMULATION PASSED" $(LOG); then \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	else \
		echo "test passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
